// ==== common/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_RESET_PC     30'h0000_0000   // Word address after reset.
`define EXTENSION_Zicsr 1'b1            // CSR instructions enabled.

// ==========================================================================
// Major opcodes
// ==========================================================================
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_OP        7'b0110011
`define RV_OP_MISC_MEM  7'b0001111
`define RV_OP_SYSTEM    7'b1110011

// ==========================================================================
// ALU control codes
// ==========================================================================
`define RV_ALU_ADD      5'd0
`define RV_ALU_SUB      5'd1
`define RV_ALU_SLL      5'd2
`define RV_ALU_SLT      5'd3
`define RV_ALU_SLTU     5'd4
`define RV_ALU_XOR      5'd5
`define RV_ALU_SRL      5'd6
`define RV_ALU_SRA      5'd7
`define RV_ALU_OR       5'd8
`define RV_ALU_AND      5'd9
`define RV_ALU_PASS     5'd10           // Operand B straight through, for LUI.

`endif

// ==== common/rv_pkg.sv ====
package rv_pkg;

    // Raw instruction word.
    typedef logic [31:0] instr_t;

    // Word address, byte offset bits dropped.
    typedef logic [31:2] pc_t;

    // Register file index.
    typedef logic [4:0] reg_idx_t;

    // Sign-extended immediate.
    typedef logic [31:0] imm_t;

    // ALU operation, codes in rv_defs.svh.
    typedef logic [4:0] alu_ctrl_t;

    // Writeback source: 0 ALU, 1 memory, 2 PC+4, 3 CSR.
    typedef logic [1:0] res_src_t;

    // CSR address.
    typedef logic [11:0] csr_idx_t;

    // CSR operation: 1 write, 2 set, 3 clear.
    typedef logic [1:0] csr_op_t;

endpackage

// ==== decode/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_stall,
    input  logic                i_flush,
    input  rv_pkg::instr_t      i_data,
    input  rv_pkg::pc_t         i_pc,
    input  rv_pkg::pc_t         i_pc_p4,
    output rv_pkg::reg_idx_t    o_rs1,
    output rv_pkg::reg_idx_t    o_rs2,
    output rv_pkg::reg_idx_t    o_rd,
    output rv_pkg::pc_t         o_pc,
    output rv_pkg::pc_t         o_pc_p4,
    output rv_pkg::imm_t        o_imm,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_pc_sel,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_alu_op1_sel,
    output logic                o_alu_op2_sel,
    output logic [2:0]          o_funct3,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl,
    output rv_pkg::csr_idx_t    o_csr_idx,
    output rv_pkg::csr_op_t     o_csr_op,
    output logic                o_csr_sel,
    output rv_pkg::pc_t         o_jump_addr,
    output logic                o_inv_instr
);

    rv_pkg::pc_t    r_pc;
    rv_pkg::pc_t    r_pc_p4;
    rv_pkg::instr_t r_instr;
    rv_pkg::instr_t w_instr;
    logic           r_flush;
    logic           r_stall;

    // ==========================================================================
    // Stage registers
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (i_flush)
        begin
            r_pc    <= '0;              // Bubble carries no PC.
            r_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            r_pc    <= i_pc;
            r_pc_p4 <= i_pc_p4;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_flush <= 1'b0;
            r_stall <= 1'b0;
        end
        else
        begin
            r_flush <= i_flush;
            r_stall <= i_stall;
        end
    end

    // Copy of the decoded word that stays frozen under stall.
    always_ff @(posedge i_clk)
    begin
        if (!r_stall)
        begin
            r_instr <= w_instr;
        end
    end

    always_comb
    begin
        if (i_reset || r_flush)
            w_instr = '0;               // Bubble.
        else if (r_stall)
            w_instr = r_instr;
        else
            w_instr = i_data;
    end

    // ==========================================================================
    // Decode
    // ==========================================================================
    rv_instr_decode u_instr_decode
    (
        .i_instr        (w_instr),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_res_src      (o_res_src),
        .o_pc_sel       (o_pc_sel),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_funct3       (o_funct3),
        .o_alu_ctrl     (o_alu_ctrl),
        .o_csr_idx      (o_csr_idx),
        .o_csr_op       (o_csr_op),
        .o_csr_sel      (o_csr_sel),
        .o_inv_instr    (o_inv_instr)
    );

    rv_imm_gen u_imm_gen
    (
        .i_instr        (w_instr),
        .o_imm          (o_imm)
    );

    assign o_pc        = r_pc;
    assign o_pc_p4     = r_pc_p4;
    assign o_jump_addr = r_pc + o_imm[31:2];    // PC-relative target in words.

endmodule

// ==== decode/rv_imm_gen.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_imm_gen
(
    input  rv_pkg::instr_t  i_instr,
    output rv_pkg::imm_t    o_imm
);

    logic w_sign;

    assign w_sign = i_instr[31];

    // Format follows the opcode.
    always_comb
    begin
        case (i_instr[6:0])
            `RV_OP_LOAD, `RV_OP_OP_IMM, `RV_OP_JALR:
                o_imm = {{20{w_sign}}, i_instr[31:20]};
            `RV_OP_STORE:
                o_imm = {{20{w_sign}}, i_instr[31:25], i_instr[11:7]};
            `RV_OP_BRANCH:
                o_imm = {{19{w_sign}}, w_sign, i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC:
                o_imm = {i_instr[31:12], 12'b0};
            `RV_OP_JAL:
                o_imm = {{11{w_sign}}, w_sign, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            default:
                o_imm = '0;         // R-type, CSR and bubble.
        endcase
    end

endmodule

// ==== decode/rv_instr_decode.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_instr_decode
(
    input  rv_pkg::instr_t      i_instr,
    output rv_pkg::reg_idx_t    o_rs1,
    output rv_pkg::reg_idx_t    o_rs2,
    output rv_pkg::reg_idx_t    o_rd,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_pc_sel,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_alu_op1_sel,
    output logic                o_alu_op2_sel,
    output logic [2:0]          o_funct3,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl,
    output rv_pkg::csr_idx_t    o_csr_idx,
    output rv_pkg::csr_op_t     o_csr_op,
    output logic                o_csr_sel,
    output logic                o_inv_instr
);

    logic [6:0]         w_opcode;
    logic [2:0]         w_funct3;
    logic [6:0]         w_funct7;
    logic               w_alt;
    logic               w_bubble;
    logic               w_valid;
    rv_pkg::alu_ctrl_t  w_alu_arith;

    assign w_opcode = i_instr[6:0];
    assign w_funct3 = i_instr[14:12];
    assign w_funct7 = i_instr[31:25];
    assign w_alt    = (w_funct7 == 7'b0100000);     // SUB / SRA form.
    assign w_bubble = (i_instr == '0);

    assign o_rs1       = i_instr[19:15];
    assign o_rs2       = i_instr[24:20];
    assign o_rd        = i_instr[11:7];
    assign o_funct3    = w_funct3;
    assign o_csr_idx   = i_instr[31:20];
    assign o_csr_op    = w_funct3[1:0];
    assign o_inv_instr = !w_valid && !w_bubble;

    // Register and immediate arithmetic.
    always_comb
    begin
        case (w_funct3)
            3'b000:  w_alu_arith = (w_opcode == `RV_OP_OP && w_alt) ? `RV_ALU_SUB : `RV_ALU_ADD;
            3'b001:  w_alu_arith = `RV_ALU_SLL;
            3'b010:  w_alu_arith = `RV_ALU_SLT;
            3'b011:  w_alu_arith = `RV_ALU_SLTU;
            3'b100:  w_alu_arith = `RV_ALU_XOR;
            3'b101:  w_alu_arith = w_alt ? `RV_ALU_SRA : `RV_ALU_SRL;
            3'b110:  w_alu_arith = `RV_ALU_OR;
            default: w_alu_arith = `RV_ALU_AND;
        endcase
    end

    // ==========================================================================
    // Control per opcode
    // ==========================================================================
    always_comb
    begin
        o_reg_write   = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_res_src     = 2'd0;               // ALU result.
        o_pc_sel      = 1'b0;
        o_jump        = 1'b0;
        o_branch      = 1'b0;
        o_alu_op1_sel = 1'b0;               // rs1.
        o_alu_op2_sel = 1'b0;               // rs2.
        o_alu_ctrl    = `RV_ALU_ADD;
        o_csr_sel     = 1'b0;
        w_valid       = 1'b0;
        case (w_opcode)
            `RV_OP_LUI, `RV_OP_AUIPC:
            begin
                o_reg_write   = 1'b1;
                o_alu_op1_sel = (w_opcode == `RV_OP_AUIPC);
                o_alu_op2_sel = 1'b1;
                o_alu_ctrl    = (w_opcode == `RV_OP_LUI) ? `RV_ALU_PASS : `RV_ALU_ADD;
                w_valid       = 1'b1;
            end
            `RV_OP_JAL, `RV_OP_JALR:
            begin
                o_reg_write   = 1'b1;
                o_res_src     = 2'd2;       // Link address.
                o_jump        = 1'b1;
                o_pc_sel      = (w_opcode == `RV_OP_JALR);    // Base is rs1.
                o_alu_op2_sel = 1'b1;
                w_valid       = (w_opcode == `RV_OP_JAL) || (w_funct3 == 3'b000);
            end
            `RV_OP_BRANCH:
            begin
                o_branch   = 1'b1;
                o_alu_ctrl = !w_funct3[2] ? `RV_ALU_SUB :
                             (w_funct3[1] ? `RV_ALU_SLTU : `RV_ALU_SLT);
                w_valid    = (w_funct3[2:1] != 2'b01);
            end
            `RV_OP_LOAD:
            begin
                o_reg_write   = 1'b1;
                o_mem_read    = 1'b1;
                o_res_src     = 2'd1;
                o_alu_op2_sel = 1'b1;
                w_valid       = (w_funct3 != 3'b011) && (w_funct3[2:1] != 2'b11);
            end
            `RV_OP_STORE:
            begin
                o_mem_write   = 1'b1;
                o_alu_op2_sel = 1'b1;
                w_valid       = !w_funct3[2] && (w_funct3[1:0] != 2'b11);
            end
            `RV_OP_OP_IMM:
            begin
                o_reg_write   = 1'b1;
                o_alu_op2_sel = 1'b1;
                o_alu_ctrl    = w_alu_arith;
                if (w_funct3 == 3'b001)
                    w_valid = (w_funct7 == 7'b0);
                else if (w_funct3 == 3'b101)
                    w_valid = (w_funct7 == 7'b0) || w_alt;
                else
                    w_valid = 1'b1;
            end
            `RV_OP_OP:
            begin
                o_reg_write = 1'b1;
                o_alu_ctrl  = w_alu_arith;
                w_valid     = (w_funct7 == 7'b0) ||
                              (w_alt && (w_funct3 == 3'b000 || w_funct3 == 3'b101));
            end
            `RV_OP_MISC_MEM:
            begin
                w_valid = (w_funct3[2:1] == 2'b00);     // FENCE, no-op here.
            end
            `RV_OP_SYSTEM:
            begin
                if (`EXTENSION_Zicsr && w_funct3[1:0] != 2'b00)
                begin
                    o_reg_write = 1'b1;
                    o_res_src   = 2'd3;     // Old CSR value to rd.
                    o_csr_sel   = 1'b1;
                    w_valid     = 1'b1;
                end
            end
            default:
            begin
                w_valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_stall,
    input  logic                i_flush,
    input  rv_pkg::pc_t         i_redirect_pc,
    input  rv_pkg::instr_t      i_imem_data,
    output rv_pkg::pc_t         o_imem_addr,
    output rv_pkg::reg_idx_t    o_rs1,
    output rv_pkg::reg_idx_t    o_rs2,
    output rv_pkg::reg_idx_t    o_rd,
    output rv_pkg::pc_t         o_pc,
    output rv_pkg::pc_t         o_pc_p4,
    output rv_pkg::imm_t        o_imm,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_pc_sel,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_alu_op1_sel,
    output logic                o_alu_op2_sel,
    output logic [2:0]          o_funct3,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl,
    output rv_pkg::csr_idx_t    o_csr_idx,
    output rv_pkg::csr_op_t     o_csr_op,
    output logic                o_csr_sel,
    output rv_pkg::pc_t         o_jump_addr,
    output logic                o_inv_instr
);

    rv_pkg::pc_t w_pc_p4;

    rv_fetch_pc u_fetch_pc
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_redirect_pc  (i_redirect_pc),
        .o_pc           (o_imem_addr),      // Also the memory address.
        .o_pc_p4        (w_pc_p4)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_data         (i_imem_data),
        .i_pc           (o_imem_addr),
        .i_pc_p4        (w_pc_p4),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_pc           (o_pc),
        .o_pc_p4        (o_pc_p4),
        .o_imm          (o_imm),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_res_src      (o_res_src),
        .o_pc_sel       (o_pc_sel),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_funct3       (o_funct3),
        .o_alu_ctrl     (o_alu_ctrl),
        .o_csr_idx      (o_csr_idx),
        .o_csr_op       (o_csr_op),
        .o_csr_sel      (o_csr_sel),
        .o_jump_addr    (o_jump_addr),
        .o_inv_instr    (o_inv_instr)
    );

endmodule

// ==== rtl/rv_fetch_pc.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_fetch_pc
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_stall,
    input  logic            i_flush,
    input  rv_pkg::pc_t     i_redirect_pc,
    output rv_pkg::pc_t     o_pc,
    output rv_pkg::pc_t     o_pc_p4
);

    rv_pkg::pc_t r_pc;
    rv_pkg::pc_t w_pc_next;

    assign w_pc_next = r_pc + 30'd1;    // Next sequential word.

    // Reset first, then redirect, then hold.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_pc <= `RV_RESET_PC;
        end
        else if (i_flush)
        begin
            r_pc <= i_redirect_pc;
        end
        else if (!i_stall)
        begin
            r_pc <= w_pc_next;
        end
    end

    assign o_pc    = r_pc;
    assign o_pc_p4 = w_pc_next;         // Return address for jumps.

endmodule

// ==== verification/decode_input.txt ====
// test stall flush redirect data | expected: imem_addr pc pc_p4 rd rs1 rs2 imm
// ctrl={csr_idx,funct3,csr_op,csr_sel,rw,mr,mw,res_src,pc_sel,jump,branch,op1,op2} alu jaddr inv
1 0 0 00000000 00000000 00000000 00000000 00000001 00 00 00 00000000 0000000 00 00000000 0
1 0 0 00000000 402081B3 00000001 00000000 00000001 03 01 02 00000000 4020200 01 00000000 0
1 0 0 00000000 FFC30293 00000002 00000001 00000002 05 06 1c FFFFFFFC FFC0201 00 00000000 0
1 0 0 00000000 00812383 00000003 00000002 00000003 07 02 08 00000008 0085321 00 00000004 0
1 0 0 00000000 00922623 00000004 00000003 00000004 0c 04 09 0000000c 0095081 00 00000006 0
1 0 0 00000000 FE208CE3 00000005 00000004 00000005 19 01 02 FFFFFFF8 FE20004 01 00000002 0
1 0 0 00000000 12345537 00000006 00000005 00000006 0a 08 03 12345000 123AA01 0a 048D1405 0
1 0 0 00000000 010000EF 00000007 00000006 00000007 01 00 10 00000010 0100249 00 0000000a 0
1 0 0 00000000 004280E7 00000008 00000007 00000008 01 05 04 00000004 0040259 00 00000008 0
2 1 0 00000000 FFC30293 00000009 00000008 00000009 05 06 1c FFFFFFFC FFC0201 00 00000007 0
2 0 0 00000000 12345537 00000009 00000008 00000009 05 06 1c FFFFFFFC FFC0201 00 00000007 0
2 0 0 00000000 00922623 0000000a 00000009 0000000a 0c 04 09 0000000c 0095081 00 0000000c 0
3 0 1 00000040 010000EF 0000000b 0000000a 0000000b 01 00 10 00000010 0100249 00 0000000e 0
3 0 0 00000000 402081B3 00000040 00000000 00000000 00 00 00 00000000 0000000 00 00000000 0
3 0 0 00000000 00812383 00000041 00000040 00000041 07 02 08 00000008 0085321 00 00000042 0
4 0 0 00000000 300312F3 00000042 00000041 00000042 05 06 00 00000000 3002E60 00 00000041 0
4 0 0 00000000 3413A373 00000043 00000042 00000043 06 07 01 00000000 3415660 00 00000042 0
4 0 0 00000000 3050B073 00000044 00000043 00000044 00 01 05 00000000 3057E60 00 00000043 0
4 0 0 00000000 0000007F 00000045 00000044 00000045 00 00 00 00000000 0000000 00 00000044 1
4 0 0 00000000 00000000 00000046 00000045 00000046 00 00 00 00000000 0000000 00 00000045 0

// ==== verification/rv_decode_checker.sv ====
`timescale 1ns/1ps

module rv_decode_checker
(
    input  logic               i_clk,
    input  logic               i_check,
    input  logic               i_finish,
    input  logic [15:0][31:0]  i_exp,
    input  logic [29:0]        i_imem_addr,
    input  logic [29:0]        i_pc,
    input  logic [29:0]        i_pc_p4,
    input  logic [4:0]         i_rd,
    input  logic [4:0]         i_rs1,
    input  logic [4:0]         i_rs2,
    input  logic [31:0]        i_imm,
    input  logic [27:0]        i_ctrl,
    input  logic [4:0]         i_alu_ctrl,
    input  logic [29:0]        i_jump_addr,
    input  logic               i_inv_instr,
    output logic               o_done,
    output logic               o_fail
);

    int cur_test;
    int test_errors;
    int test_cycles;
    int tests_passed;
    int tests_failed;
    int errors;

    initial
    begin
        cur_test     = -1;
        test_errors  = 0;
        test_cycles  = 0;
        tests_passed = 0;
        tests_failed = 0;
        errors       = 0;
        o_done       = 1'b0;
        o_fail       = 1'b0;
    end

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        begin
            if (exp !== act)
            begin
                $display("mismatch at %0d ns: %s expected %h, actual %h",
                         $time, name, exp, act);
                test_errors++;
                errors++;
            end
        end
    endtask

    task automatic close_test;
        begin
            if (cur_test >= 0)
            begin
                if (test_errors == 0)
                begin
                    tests_passed++;
                    $display("test %0d passed over %0d cycles", cur_test, test_cycles);
                end
                else
                begin
                    tests_failed++;
                    $display("test %0d failed with %0d mismatches", cur_test, test_errors);
                end
            end
        end
    endtask

    // ========================================================================
    // Comparison on the falling edge
    // ========================================================================
    always @(negedge i_clk)
    begin
        if (i_check)
        begin
            if (i_exp[0] != cur_test)
            begin
                close_test();
                cur_test    = i_exp[0];
                test_errors = 0;
                test_cycles = 0;
            end
            test_cycles++;
            compare_field("o_imem_addr", i_exp[5], {2'b0, i_imem_addr});
            compare_field("o_pc", i_exp[6], {2'b0, i_pc});
            compare_field("o_pc_p4", i_exp[7], {2'b0, i_pc_p4});
            compare_field("o_rd", i_exp[8], {27'b0, i_rd});
            compare_field("o_rs1", i_exp[9], {27'b0, i_rs1});
            compare_field("o_rs2", i_exp[10], {27'b0, i_rs2});
            compare_field("o_imm", i_exp[11], i_imm);
            compare_field("control", i_exp[12], {4'b0, i_ctrl});
            compare_field("o_alu_ctrl", i_exp[13], {27'b0, i_alu_ctrl});
            compare_field("o_jump_addr", i_exp[14], {2'b0, i_jump_addr});
            compare_field("o_inv_instr", i_exp[15], {31'b0, i_inv_instr});
        end
        else if (i_finish && !o_done)
        begin
            close_test();
            cur_test = -1;
            $display("%0d tests passed, %0d tests failed, %0d mismatches",
                     tests_passed, tests_failed, errors);
            o_fail = (tests_failed != 0) || (tests_passed == 0);
            o_done = 1'b1;
        end
    end

endmodule

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/1ps

module tb_rv_decode;

    localparam int MAX_LINES = 64;

    logic                i_clk;
    logic                i_reset;
    logic                i_stall;
    logic                i_flush;
    rv_pkg::pc_t         i_redirect_pc;
    rv_pkg::instr_t      i_imem_data;

    rv_pkg::pc_t         imem_addr;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::pc_t         pc;
    rv_pkg::pc_t         pc_p4;
    rv_pkg::imm_t        imm;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    rv_pkg::res_src_t    res_src;
    logic                pc_sel;
    logic                jump;
    logic                branch;
    logic                alu_op1_sel;
    logic                alu_op2_sel;
    logic [2:0]          funct3;
    rv_pkg::alu_ctrl_t   alu_ctrl;
    rv_pkg::csr_idx_t    csr_idx;
    rv_pkg::csr_op_t     csr_op;
    logic                csr_sel;
    rv_pkg::pc_t         jump_addr;
    logic                inv_instr;

    // One row per data line with the columns in file order.
    logic [31:0]         f_col[0:MAX_LINES-1][0:15];
    logic [15:0][31:0]   exp_col;

    int          n_lines;
    int          line_idx;
    int          cycle_count;
    int          cycle_limit;
    logic        check_en;
    logic        finish_req;
    logic        chk_done;
    logic        chk_fail;

    always #5 i_clk = ~i_clk;

    // ========================================================================
    // File reading and stimulus
    // ========================================================================
    task automatic read_stimulus;
        int              fd;
        int              cnt;
        reg [8*256-1:0]  text;
        logic [31:0]     v[0:15];
        begin
            n_lines = 0;
            fd = $fopen("verification/decode_input.txt", "r");
            if (fd != 0)
            begin
                while ($fgets(text, fd) != 0 && n_lines < MAX_LINES)
                begin
                    cnt = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                  v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                    if (cnt == 16)
                    begin
                        for (int c = 0; c < 16; c++)
                            f_col[n_lines][c] = v[c];
                        n_lines++;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    task automatic apply_line(input int k);
        begin
            i_stall       <= f_col[k][1][0];
            i_flush       <= f_col[k][2][0];
            i_redirect_pc <= f_col[k][3][29:0];
            i_imem_data   <= f_col[k][4];
            for (int c = 0; c < 16; c++)
                exp_col[c] <= f_col[k][c];
            check_en      <= 1'b1;
        end
    endtask

    rv_decode_top i_dut
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_redirect_pc  (i_redirect_pc),
        .i_imem_data    (i_imem_data),
        .o_imem_addr    (imem_addr),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .o_rd           (rd),
        .o_pc           (pc),
        .o_pc_p4        (pc_p4),
        .o_imm          (imm),
        .o_reg_write    (reg_write),
        .o_mem_read     (mem_read),
        .o_mem_write    (mem_write),
        .o_res_src      (res_src),
        .o_pc_sel       (pc_sel),
        .o_jump         (jump),
        .o_branch       (branch),
        .o_alu_op1_sel  (alu_op1_sel),
        .o_alu_op2_sel  (alu_op2_sel),
        .o_funct3       (funct3),
        .o_alu_ctrl     (alu_ctrl),
        .o_csr_idx      (csr_idx),
        .o_csr_op       (csr_op),
        .o_csr_sel      (csr_sel),
        .o_jump_addr    (jump_addr),
        .o_inv_instr    (inv_instr)
    );

    rv_decode_checker u_checker
    (
        .i_clk          (i_clk),
        .i_check        (check_en),
        .i_finish       (finish_req),
        .i_exp          (exp_col),
        .i_imem_addr    (imem_addr),
        .i_pc           (pc),
        .i_pc_p4        (pc_p4),
        .i_rd           (rd),
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .i_imm          (imm),
        .i_ctrl         ({csr_idx, funct3, csr_op, csr_sel, reg_write, mem_read, mem_write,
                          res_src, pc_sel, jump, branch, alu_op1_sel, alu_op2_sel}),
        .i_alu_ctrl     (alu_ctrl),
        .i_jump_addr    (jump_addr),
        .i_inv_instr    (inv_instr),
        .o_done         (chk_done),
        .o_fail         (chk_fail)
    );

    // Run limit.
    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run passed %0d cycles before the checker finished.",
                     cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial
    begin
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_redirect_pc = '0;
        i_imem_data   = '0;
        check_en      = 1'b0;
        finish_req    = 1'b0;
        cycle_count   = 0;
        cycle_limit   = 20;
        for (int c = 0; c < 16; c++)
            exp_col[c] = '0;
        read_stimulus();
        cycle_limit = n_lines + 4 + 16;     // File lines, reset, margin.
        if (n_lines == 0)
        begin
            $display("No stimulus lines could be read from verification/decode_input.txt.");
            $display("Test FAILED");
            $finish;
        end
        else
        begin
            repeat (4) @(posedge i_clk);
            i_reset <= 1'b0;
            for (line_idx = 0; line_idx < n_lines; line_idx++)
            begin
                if (line_idx > 0)
                    @(posedge i_clk);
                apply_line(line_idx);
            end
            @(posedge i_clk);
            check_en   <= 1'b0;
            finish_req <= 1'b1;
            wait (chk_done);
            if (chk_fail)
                $display("Test FAILED");
            else
                $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/rv_pkg.sv
rtl/rv_fetch_pc.sv
decode/rv_imm_gen.sv
decode/rv_instr_decode.sv
decode/rv_decode.sv
rtl/rv_decode_top.sv
verification/rv_decode_checker.sv
verification/tb_rv_decode.sv
